// ==== design/axi_st_link_pkg.sv ====
// Shared definitions for the AXI-stream die-to-die transmit link
//   Vector widths with a meaning (data, keep, delays, PHY word, debug)
//   Link word struct as packed for the PHY halves
//   Tx sync state encoding
//   PHY half layout positions for marker and strobe

package axi_st_link_pkg;

  // PHY half layout
  localparam int HALF_W      = 40;
  localparam int HALF_DATA_W = 37;
  // Strobe sits just below the marker in each half
  localparam int STB_POS     = 38;
  localparam int MRK_POS     = 39;
  localparam int MARKER_W    = 1;

  // User stream fields
  typedef logic [63:0] data_t;
  typedef logic [7:0]  keep_t;

  // Online delay and sync window counts
  typedef logic [15:0] delay_t;

  // One PHY channel, two halves
  typedef logic [2*HALF_W-1:0] phy_word_t;

  typedef logic [31:0] debug_t;

  // 74-bit link word, valid on top, data at the bottom
  typedef struct packed {
    logic  tvalid;
    logic  tlast;
    keep_t tkeep;
    data_t tdata;
  } st_word_t;

  // Tx side qualification
  typedef enum logic [1:0] {
    SYNC_OFFLINE = 2'd0,
    SYNC_DELAY   = 2'd1,
    SYNC_WINDOW  = 2'd2,
    SYNC_ONLINE  = 2'd3
  } sync_state_t;

endpackage

// ==== design/ll_auto_sync.sv ====
// Online qualification for the logic link
//   Rx online delay counter
//   Tx online FSM with a shared delay/window counter
//   Marker and strobe gating into the sync window

`timescale 1ns/10ps

module ll_auto_sync import axi_st_link_pkg::*; #(
  parameter bit PERSISTENT_MARKER = 1'b0,
  parameter bit PERSISTENT_STROBE = 1'b0
) (
  input  logic                clk_wr,
  input  logic                rst_n,
  input  logic                tx_online,
  input  logic                rx_online,
  input  delay_t              delay_x_value,
  input  delay_t              delay_y_value,
  input  delay_t              delay_z_value,
  input  logic [MARKER_W-1:0] tx_mrk_userbit,
  input  logic                tx_stb_userbit,
  output logic                tx_online_delay,
  output logic                rx_online_delay,
  output logic [MARKER_W-1:0] tx_auto_mrk_userbit,
  output logic                tx_auto_stb_userbit
);

  delay_t      rx_cnt;
  delay_t      tx_cnt;
  sync_state_t state;
  logic        in_window;
  logic        mrk_en;
  logic        stb_en;

  ////////////////////////////////////////////////////////////////////////////
  // Rx side

  // Count consecutive high samples, drop at once on a low sample
  always_ff @(posedge clk_wr) begin
    if (!rst_n || !rx_online) begin
      rx_cnt          <= '0;
      rx_online_delay <= 1'b0;
    end else if (rx_cnt == delay_x_value) begin
      rx_online_delay <= 1'b1;
    end else begin
      rx_cnt <= rx_cnt + 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Tx side

  always_ff @(posedge clk_wr) begin
    if (!rst_n || !tx_online) begin
      state  <= SYNC_OFFLINE;
      tx_cnt <= '0;
    end else begin
      case (state)
        // Offline and delay share the count of high samples
        SYNC_OFFLINE, SYNC_DELAY: begin
          if (tx_cnt == delay_y_value) begin
            tx_cnt <= '0;
            // Zero window goes straight to online
            state  <= (delay_z_value == '0) ? SYNC_ONLINE : SYNC_WINDOW;
          end else begin
            tx_cnt <= tx_cnt + 1'b1;
            state  <= SYNC_DELAY;
          end
        end
        // Window counts from the edge where online rose
        SYNC_WINDOW: begin
          if (tx_cnt == delay_z_value - 1'b1) begin
            tx_cnt <= '0;
            state  <= SYNC_ONLINE;
          end else begin
            tx_cnt <= tx_cnt + 1'b1;
          end
        end
        default: begin
          tx_cnt <= '0;
        end
      endcase
    end
  end

  // Online once delay is done
  assign tx_online_delay = (state == SYNC_WINDOW) || (state == SYNC_ONLINE);
  assign in_window       = (state == SYNC_WINDOW);

  // Persistent bits pass whenever online
  assign mrk_en = PERSISTENT_MARKER ? tx_online_delay : in_window;
  assign stb_en = PERSISTENT_STROBE ? tx_online_delay : in_window;

  assign tx_auto_mrk_userbit = tx_mrk_userbit & {MARKER_W{mrk_en}};
  assign tx_auto_stb_userbit = tx_stb_userbit & stb_en;

endmodule

// ==== design/axi_st_d64_nordy_master_name.sv ====
// User side packing for the 64-bit no-ready AXI-stream master
//   Beat fields into the 74-bit link word
//   Word forced to zero while the far side is offline

`timescale 1ns/10ps

module axi_st_d64_nordy_master_name import axi_st_link_pkg::*; (
  input  keep_t    user_tkeep,
  input  data_t    user_tdata,
  input  logic     user_tlast,
  input  logic     user_tvalid,
  input  logic     rx_online,
  output st_word_t txfifo_st_data
);

  // No handshake, every beat is packed as presented
  always_comb begin
    txfifo_st_data = '0;
    // Nothing leaks before the far side is up
    if (rx_online) begin
      txfifo_st_data.tvalid = user_tvalid;
      txfifo_st_data.tlast  = user_tlast;
      txfifo_st_data.tkeep  = user_tkeep;
      txfifo_st_data.tdata  = user_tdata;
    end
  end

endmodule

// ==== design/axi_st_d64_nordy_master_concat.sv ====
// PHY mapping for the no-ready AXI-stream master
//   Split of the link word into two 37-bit half payloads
//   Marker and strobe placement for gen1 and gen2
//   Registered 80-bit PHY word, zero while offline

`timescale 1ns/10ps

module axi_st_d64_nordy_master_concat import axi_st_link_pkg::*; (
  input  logic                clk_wr,
  input  logic                rst_n,
  input  st_word_t            tx_st_data,
  input  logic                m_gen2_mode,
  input  logic                tx_online,
  input  logic [MARKER_W-1:0] tx_mrk_userbit,
  input  logic                tx_stb_userbit,
  output phy_word_t           tx_phy0
);

  logic [HALF_DATA_W-1:0] lo_payload;
  logic [HALF_DATA_W-1:0] hi_payload;
  logic [HALF_W-1:0]      lo_half;
  logic [HALF_W-1:0]      hi_half;

  // One PHY half, spare bit above the payload stays zero
  function automatic logic [HALF_W-1:0] build_half(
    input logic [HALF_DATA_W-1:0] payload,
    input logic                   stb,
    input logic [MARKER_W-1:0]    mrk,
    input logic                   with_bits
  );
    logic [HALF_W-1:0] half;
    half = '0;
    half[HALF_DATA_W-1:0] = payload;
    if (with_bits) begin
      half[STB_POS]             = stb;
      half[MRK_POS +: MARKER_W] = mrk;
    end
    return half;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Half split

  // Low half carries the data end of the word
  assign lo_payload = tx_st_data[HALF_DATA_W-1:0];
  assign hi_payload = tx_st_data[2*HALF_DATA_W-1:HALF_DATA_W];

  // Gen2 keeps marker and strobe in the upper half only
  assign lo_half = build_half(lo_payload, tx_stb_userbit, tx_mrk_userbit, !m_gen2_mode);
  assign hi_half = build_half(hi_payload, tx_stb_userbit, tx_mrk_userbit, 1'b1);

  ////////////////////////////////////////////////////////////////////////////
  // Output register

  always_ff @(posedge clk_wr) begin
    if (!rst_n || !tx_online) begin
      tx_phy0 <= '0;
    end else begin
      tx_phy0 <= {hi_half, lo_half};
    end
  end

endmodule

// ==== design/axi_st_d64_nordy_master_top.sv ====
// Top level of the 64-bit no-ready AXI-stream link master
//   Online sync block, user packing and PHY mapping
//   Direct link word path, no FIFO or credits
//   Debug status with the two delayed online bits

`timescale 1ns/10ps

module axi_st_d64_nordy_master_top import axi_st_link_pkg::*; (
  input  logic                clk_wr,
  input  logic                rst_n,

  // Link control
  input  logic                tx_online,
  input  logic                rx_online,

  // PHY channel
  output phy_word_t           tx_phy0,

  // Stream beat
  input  keep_t               user_tkeep,
  input  data_t               user_tdata,
  input  logic                user_tlast,
  input  logic                user_tvalid,

  output debug_t              tx_st_debug_status,

  // Configuration
  input  logic                m_gen2_mode,
  input  logic [MARKER_W-1:0] tx_mrk_userbit,
  input  logic                tx_stb_userbit,
  input  delay_t              delay_x_value,
  input  delay_t              delay_y_value,
  input  delay_t              delay_z_value
);

  st_word_t            txfifo_st_data;
  st_word_t            tx_st_data;
  logic [MARKER_W-1:0] tx_auto_mrk_userbit;
  logic                tx_auto_stb_userbit;
  logic                tx_online_delay;
  logic                rx_online_delay;

  ////////////////////////////////////////////////////////////////////////////
  // Online qualification

  ll_auto_sync #(
    .PERSISTENT_MARKER (1'b0),
    .PERSISTENT_STROBE (1'b0)
  ) ll_auto_sync_i (
    .clk_wr              (clk_wr),
    .rst_n               (rst_n),
    .tx_online           (tx_online),
    .rx_online           (rx_online),
    .delay_x_value       (delay_x_value),
    .delay_y_value       (delay_y_value),
    .delay_z_value       (delay_z_value),
    .tx_mrk_userbit      (tx_mrk_userbit),
    .tx_stb_userbit      (tx_stb_userbit),
    .tx_online_delay     (tx_online_delay),
    .rx_online_delay     (rx_online_delay),
    .tx_auto_mrk_userbit (tx_auto_mrk_userbit),
    .tx_auto_stb_userbit (tx_auto_stb_userbit)
  );

  // No ready, so the packed word goes straight to the PHY side
  assign tx_st_data = txfifo_st_data;

  // Tx online at bit 19, rx online at bit 18
  assign tx_st_debug_status = {12'h0, tx_online_delay, rx_online_delay, 18'h0};

  ////////////////////////////////////////////////////////////////////////////
  // User side and PHY side

  axi_st_d64_nordy_master_name axi_st_d64_nordy_master_name (
    .user_tkeep     (user_tkeep),
    .user_tdata     (user_tdata),
    .user_tlast     (user_tlast),
    .user_tvalid    (user_tvalid),
    .rx_online      (rx_online_delay),
    .txfifo_st_data (txfifo_st_data)
  );

  axi_st_d64_nordy_master_concat axi_st_d64_nordy_master_concat (
    .clk_wr         (clk_wr),
    .rst_n          (rst_n),
    .tx_st_data     (tx_st_data),
    .m_gen2_mode    (m_gen2_mode),
    .tx_online      (tx_online_delay),
    .tx_mrk_userbit (tx_auto_mrk_userbit),
    .tx_stb_userbit (tx_auto_stb_userbit),
    .tx_phy0        (tx_phy0)
  );

endmodule

// ==== tests/tb_axi_st_master.sv ====
// Testbench for the no-ready AXI-stream link master
//   Clock, reset and case file reader
//   Expected PHY words built from the half layout
//   Error counts and closing result

`timescale 1ns/10ps

module tb_axi_st_master import axi_st_link_pkg::*; ();

  localparam int WAIT_LIMIT = 64;

  logic                clk_wr;
  logic                rst_n;
  logic                tx_online;
  logic                rx_online;
  keep_t               user_tkeep;
  data_t               user_tdata;
  logic                user_tlast;
  logic                user_tvalid;
  logic                m_gen2_mode;
  logic [MARKER_W-1:0] tx_mrk_userbit;
  logic                tx_stb_userbit;
  delay_t              delay_x_value;
  delay_t              delay_y_value;
  delay_t              delay_z_value;
  phy_word_t           tx_phy0;
  debug_t              tx_st_debug_status;

  // Expected delayed online bits
  logic   tx_up;
  logic   rx_up;
  int     mismatches;
  int     failures;
  integer seed;

  axi_st_d64_nordy_master_top i_axi_st_d64_nordy_master_top (.*);

  initial begin
    clk_wr = 1'b0;
    forever #10 clk_wr = ~clk_wr;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Expected values

  // Low half gets word bits 36..0, high half 73..37, bits 37 and 77 idle
  function automatic phy_word_t expected_phy(input st_word_t w, input logic gen2,
                                             input logic mrk, input logic stb);
    phy_word_t e;
    e = '0;
    e[36:0]  = w[36:0];
    e[76:40] = w[73:37];
    e[79]    = mrk;
    e[78]    = stb;
    // Gen1 repeats them in the low half
    if (!gen2) begin
      e[39] = mrk;
      e[38] = stb;
    end
    return e;
  endfunction

  task automatic check_debug();
    debug_t exp;
    exp = '0;
    exp[19] = tx_up;
    exp[18] = rx_up;
    if (tx_st_debug_status !== exp) begin
      $display("mismatch at %0t: debug status %h, expected %h", $time, tx_st_debug_status, exp);
      mismatches++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Case steps

  task automatic apply_cfg(input logic gen2, input delay_t x, input delay_t y,
                           input delay_t z);
    @(posedge clk_wr);
    m_gen2_mode   <= gen2;
    delay_x_value <= x;
    delay_y_value <= y;
    delay_z_value <= z;
  endtask

  task automatic change_online(input logic tx, input logic rx, input logic mrk,
                               input logic stb, input int exp_rx, input int exp_tx);
    int k;
    int rx_at;
    int tx_at;
    @(posedge clk_wr);
    tx_online      <= tx;
    rx_online      <= rx;
    tx_mrk_userbit <= mrk;
    tx_stb_userbit <= stb;
    rx_at = -1;
    tx_at = -1;
    k     = 0;
    @(negedge clk_wr);
    // Edges counted from the change, 0 when a bit already matches
    while ((rx_at < 0 || tx_at < 0) && k <= WAIT_LIMIT) begin
      if (rx_at < 0 && tx_st_debug_status[18] == rx) rx_at = k;
      if (tx_at < 0 && tx_st_debug_status[19] == tx) tx_at = k;
      if (rx_at < 0 || tx_at < 0) begin
        @(negedge clk_wr);
        k++;
      end
    end
    tx_up = tx;
    rx_up = rx;
    if (rx_at < 0 || tx_at < 0) begin
      $display("timeout at %0t: online bits did not follow tx %0d rx %0d in %0d cycles",
               $time, tx, rx, WAIT_LIMIT);
      failures++;
    end else if (rx_at != exp_rx || tx_at != exp_tx) begin
      $display("mismatch at %0t: online edges rx %0d tx %0d, expected rx %0d tx %0d",
               $time, rx_at, tx_at, exp_rx, exp_tx);
      mismatches++;
    end
  endtask

  task automatic send_beat(input logic tv, input logic tl, input keep_t keep,
                           input data_t data, input logic mrk, input logic stb);
    st_word_t  w;
    phy_word_t exp;
    @(posedge clk_wr);
    user_tvalid <= tv;
    user_tlast  <= tl;
    user_tkeep  <= keep;
    user_tdata  <= data;
    // Sampled on the next edge, registered onto the PHY there
    @(posedge clk_wr);
    @(negedge clk_wr);
    w = '0;
    if (rx_up) w = {tv, tl, keep, data};
    exp = tx_up ? expected_phy(w, m_gen2_mode, mrk, stb) : '0;
    if (tx_phy0 !== exp) begin
      $display("mismatch at %0t: tx_phy0 %h, expected %h", $time, tx_phy0, exp);
      mismatches++;
    end
    check_debug();
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence

  initial begin
    int               fd;
    int               n;
    int               f_erx;
    int               f_etx;
    logic [8*160-1:0] line;
    logic [8*8-1:0]   kw;
    logic [8*20-1:0]  dstr;
    logic             f_a;
    logic             f_b;
    logic             f_c;
    logic             f_d;
    delay_t           f_x;
    delay_t           f_y;
    delay_t           f_z;
    keep_t            f_keep;
    data_t            f_data;
    seed           = 32'h717a437a;
    mismatches     = 0;
    failures       = 0;
    tx_up          = 1'b0;
    rx_up          = 1'b0;
    rst_n          = 1'b0;
    tx_online      = 1'b0;
    rx_online      = 1'b0;
    user_tkeep     = '0;
    user_tdata     = '0;
    user_tlast     = 1'b0;
    user_tvalid    = 1'b0;
    m_gen2_mode    = 1'b0;
    tx_mrk_userbit = '0;
    tx_stb_userbit = 1'b0;
    delay_x_value  = '0;
    delay_y_value  = '0;
    delay_z_value  = '0;
    repeat (10) @(posedge clk_wr);
    rst_n <= 1'b1;
    @(negedge clk_wr);
    // Reset state
    check_debug();
    if (tx_phy0 !== '0) begin
      $display("mismatch at %0t: tx_phy0 %h after reset", $time, tx_phy0);
      mismatches++;
    end
    fd = $fopen("tests/axi_st_link_cases.txt", "r");
    if (fd == 0) begin
      $display("could not open the case file tests/axi_st_link_cases.txt");
      failures++;
    end else begin
      while (!$feof(fd)) begin
        line = '0;
        kw   = '0;
        n    = $fgets(line, fd);
        n    = $sscanf(line, "%s", kw);
        // Comment and blank lines fall through
        if (kw == "CFG") begin
          n = $sscanf(line, "%s %d %d %d %d", kw, f_a, f_x, f_y, f_z);
          apply_cfg(f_a, f_x, f_y, f_z);
        end else if (kw == "ONLINE") begin
          n = $sscanf(line, "%s %d %d %d %d %d %d", kw, f_a, f_b, f_c, f_d, f_erx, f_etx);
          change_online(f_a, f_b, f_c, f_d, f_erx, f_etx);
        end else if (kw == "BEAT") begin
          n = $sscanf(line, "%s %d %d %h %s %d %d", kw, f_a, f_b, f_keep, dstr, f_c, f_d);
          if (dstr == "*") f_data = {$random(seed), $random(seed)};
          else n = $sscanf(dstr, "%h", f_data);
          send_beat(f_a, f_b, f_keep, f_data, f_c, f_d);
        end
      end
      $fclose(fd);
    end
    $display("mismatches %0d, other failures %0d", mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// ==== tests/axi_st_master_assert.sv ====
// Concurrent checks on the link master
//   PHY word idle while tx is not qualified
//   Spare bits 37 and 77 of the PHY word
//   Auto marker and strobe quiet while offline

`timescale 1ns/10ps

module axi_st_master_assert import axi_st_link_pkg::*; (
  input logic                clk_wr,
  input logic                rst_n,
  input phy_word_t           tx_phy0,
  input logic                tx_online_delay,
  input logic [MARKER_W-1:0] tx_auto_mrk_userbit,
  input logic                tx_auto_stb_userbit
);

  // Output register loads zero on the edge after an offline sample
  phy_idle_offline: assert property (@(posedge clk_wr) disable iff (!rst_n)
    !tx_online_delay |=> tx_phy0 == '0)
    else $error("tx_phy0 not zero one cycle after tx_online_delay low");

  spare_bits_zero: assert property (@(posedge clk_wr) disable iff (!rst_n)
    !tx_phy0[37] && !tx_phy0[77])
    else $error("tx_phy0 spare bit 37 or 77 set");

  // Sync window only opens once tx is qualified
  auto_bits_offline: assert property (@(posedge clk_wr) disable iff (!rst_n)
    !tx_online_delay |-> (tx_auto_mrk_userbit == '0 && !tx_auto_stb_userbit))
    else $error("auto marker or strobe set while tx_online_delay low");

endmodule

bind axi_st_d64_nordy_master_top axi_st_master_assert i_axi_st_master_assert (
  .clk_wr              (clk_wr),
  .rst_n               (rst_n),
  .tx_phy0             (tx_phy0),
  .tx_online_delay     (tx_online_delay),
  .tx_auto_mrk_userbit (tx_auto_mrk_userbit),
  .tx_auto_stb_userbit (tx_auto_stb_userbit)
);

// ==== src.f ====
design/axi_st_link_pkg.sv
design/ll_auto_sync.sv
design/axi_st_d64_nordy_master_name.sv
design/axi_st_d64_nordy_master_concat.sv
design/axi_st_d64_nordy_master_top.sv
tests/tb_axi_st_master.sv
tests/axi_st_master_assert.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the link master testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_axi_st_master -f src.f -o sim_axi_st_master
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sim_axi_st_master > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "No errors" sim.log; then
  echo "result: pass"
  exit 0
fi
echo "result: fail"
exit 1

// ==== tests/axi_st_link_cases.txt ====
# CFG    gen2 delay_x delay_y delay_z
# ONLINE tx rx mrk stb rx_edges tx_edges (edges until the debug bit follows, 0 if it already does)
# BEAT   tvalid tlast tkeep(hex) tdata(hex, * for random) exp_mrk exp_stb
# Offline with user bits up, PHY must stay quiet
CFG 1 2 2 4
ONLINE 0 0 1 1 0 0
BEAT 1 1 ff 0123456789abcdef 0 0
BEAT 1 0 0f * 0 0
BEAT 0 0 00 * 0 0
# Gen2, rx qualified before tx, six edge window
CFG 1 3 5 6
ONLINE 1 1 1 1 4 6
BEAT 1 0 ff * 1 1
BEAT 1 0 a5 * 1 1
BEAT 1 1 0f * 1 1
BEAT 1 0 ff * 0 0
BEAT 0 0 00 * 0 0
ONLINE 0 0 1 1 1 1
BEAT 1 1 ff * 0 0
# Gen1, marker and strobe on both halves for four edges
CFG 0 0 2 4
ONLINE 1 1 1 1 1 3
BEAT 1 1 ff 0123456789abcdef 1 1
BEAT 1 0 3c * 1 1
BEAT 1 0 ff * 0 0
BEAT 0 1 81 * 0 0
ONLINE 0 0 1 1 1 1
# Tx up with rx held low, data zeroed, window still applies
CFG 0 0 1 2
ONLINE 1 0 1 1 0 2
BEAT 1 1 ff * 1 1
BEAT 1 0 ff * 0 0
ONLINE 0 0 0 0 0 1
# Gen2 with zero delays, strobe only, eight edge window
CFG 1 0 0 8
ONLINE 1 1 0 1 1 1
BEAT 1 0 ff * 0 1
BEAT 1 0 ff * 0 1
BEAT 1 0 ff * 0 1
BEAT 1 1 ff * 0 1
BEAT 1 0 ff * 0 0
# Far side drops while tx stays up
ONLINE 1 0 0 1 1 0
BEAT 1 1 ff * 0 0
ONLINE 0 0 0 0 0 1
